//--- project.f
verilog/coreTypes.sv
verilog/wordMemory.sv
verilog/regFile.sv
verilog/decodeUnit.sv
verilog/hazardUnit.sv
verilog/executeUnit.sv
verilog/pipelineRegisters.sv
verilog/pipelineCore.sv
verification/coreModel.sv
verification/coreTb.sv

//--- verification/coreModel.sv
// Test programs and in-order ISA model; no backward branches, random loads only read stored words
`default_nettype none

module coreModel;
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] prog [coreTypes::imemDepth];
    int          progLen;
    integer      seed = 10776;
    logic [31:0] archRegs [32];
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    logic [5:0]  expAddr [$];
    logic [31:0] expStore [$];

    // RV32I encodings, written straight from the ISA formats
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        logic [11:0] i12;
        i12 = 12'(imm);
        return {i12[11:5], 5'(rs2), 5'(rs1), 3'b010, i12[4:0], 7'b0100011};
    endfunction

    // f3 000 is BEQ, 001 is BNE
    function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int imm);
        logic [12:0] i13;
        i13 = 13'(imm);
        return {i13[12], i13[10:5], 5'(rs2), 5'(rs1), f3, i13[4:1], i13[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] aluWord(input int sel, input int rd, input int rs1,
                                            input int rs2);
        case (sel)
            0:       return rType(7'h00, 3'b000, rd, rs1, rs2);  // add
            1:       return rType(7'h20, 3'b000, rd, rs1, rs2);  // sub
            2:       return rType(7'h00, 3'b111, rd, rs1, rs2);  // and
            3:       return rType(7'h00, 3'b110, rd, rs1, rs2);  // or
            default: return rType(7'h00, 3'b010, rd, rs1, rs2);  // slt
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic commit(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            archRegs[rd] = value;
            expRd.push_back(rd);
            expData.push_back(value);
        end
    endtask

    task automatic buildProgram(input int testId);
        int stored [$];
        int kind;
        int rd;
        int r1;
        int r2;
        int word;
        progLen = 0;
        expRd.delete();
        expData.delete();
        expAddr.delete();
        expStore.delete();
        case (testId)
            1: begin
                emit(addi(1, 0, 5));
                emit(addi(2, 0, -3));
                emit(sw(2, 0, 4));
                emit(aluWord(0, 3, 1, 2));
            end
            2: begin
                emit(addi(1, 0, 7));
                emit(addi(2, 1, -2));  // Memory-stage forward
                emit(aluWord(0, 3, 2, 1));
                emit(aluWord(1, 4, 3, 1));  // x1 through regFile write-through
                emit(aluWord(2, 5, 4, 3));
                emit(aluWord(3, 6, 5, 2));
                emit(aluWord(4, 7, 6, 4));
                emit(addi(8, 0, -1));
                emit(aluWord(4, 9, 8, 7));  // Signed compare of -1
                emit(aluWord(1, 10, 9, 8));
            end
            3: begin
                emit(addi(1, 0, 100));
                emit(addi(2, 0, 8));
                emit(sw(1, 2, 4));
                emit(lw(3, 2, 4));
                emit(aluWord(0, 4, 3, 1));
                emit(sw(4, 0, 0));
                emit(lw(5, 0, 0));
                emit(sw(5, 0, 8));  // Load feeding store data
                emit(lw(6, 0, 8));
                emit(aluWord(1, 7, 6, 1));
            end
            4: begin
                emit(addi(1, 0, 3));
                emit(addi(2, 0, 3));
                emit(branch(3'b000, 1, 2, 12));  // Taken
                emit(addi(3, 0, 1));
                emit(addi(4, 0, 1));
                emit(addi(5, 0, 2));
                emit(branch(3'b001, 1, 2, 8));  // Not taken
                emit(addi(6, 0, 6));
                emit(addi(7, 0, 9));
                emit(branch(3'b001, 7, 1, 12));  // Taken
                emit(addi(8, 0, 1));
                emit(addi(9, 0, 1));
                emit(addi(10, 0, 7));
                emit(branch(3'b000, 10, 0, 8));
                emit(addi(11, 0, 5));
            end
            default: begin
                for (int i = 0; i < 40; i++) begin
                    kind = $unsigned($random(seed)) % 8;
                    rd   = $unsigned($random(seed)) % 8;
                    r1   = $unsigned($random(seed)) % 8;
                    r2   = $unsigned($random(seed)) % 8;
                    word = $unsigned($random(seed)) % 16;
                    if (kind == 7 && stored.size() != 0) begin
                        emit(lw(rd, 0, 4 * stored[word % stored.size()]));
                    end else if (kind >= 6) begin
                        emit(sw(r2, 0, 4 * word));
                        stored.push_back(word);
                    end else if (kind >= 4) begin
                        emit(addi(rd, r1, $random(seed) % 2048));
                    end else begin
                        emit(aluWord(word % 5, rd, r1, r2));
                    end
                end
            end
        endcase
        for (int i = progLen; i < coreTypes::imemDepth; i++) begin
            prog[i] = addi(0, 0, 0);
        end
        runModel();
    endtask

    task automatic runModel();
        logic [31:0]        mem [coreTypes::dmemDepth];
        logic [31:0]        w;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        res;
        logic [31:0]        addr;
        logic signed [12:0] offB;
        int                 pcIdx;
        int                 steps;
        for (int i = 0; i < 32; i++) begin
            archRegs[i] = '0;
        end
        pcIdx = 0;
        steps = 0;
        while (pcIdx < progLen && steps < 200) begin
            w = prog[pcIdx];
            a = archRegs[w[19:15]];
            b = archRegs[w[24:20]];
            pcIdx++;
            steps++;
            case (w[6:0])
                7'b0110011: begin
                    case (w[14:12])
                        3'b000:  res = w[30] ? a - b : a + b;
                        3'b111:  res = a & b;
                        3'b110:  res = a | b;
                        default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                    commit(w[11:7], res);
                end
                7'b0010011: commit(w[11:7], a + {{20{w[31]}}, w[31:20]});
                7'b0000011: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    commit(w[11:7], mem[addr[7:2]]);
                end
                7'b0100011: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    mem[addr[7:2]] = b;
                    expAddr.push_back(addr[7:2]);
                    expStore.push_back(b);
                end
                7'b1100011: begin
                    offB = {w[31], w[7], w[30:25], w[11:8], 1'b0};
                    if ((a == b) != w[12]) begin
                        pcIdx += int'(offB) / 4 - 1;  // Shadow is skipped
                    end
                end
                default: ;
            endcase
        end
    endtask

    function automatic int retiresLeft();
        return expRd.size();
    endfunction

    function automatic int storesLeft();
        return expAddr.size();
    endfunction

    task automatic popRetire(output logic [4:0] rd, output logic [31:0] data);
        rd = expRd.pop_front();
        data = expData.pop_front();
    endtask

    task automatic nextStore(output logic [5:0] addr, output logic [31:0] data);
        addr = expAddr.pop_front();
        data = expStore.pop_front();
    endtask

endmodule

`default_nettype wire

//--- verification/coreTb.sv
// Testbench for pipelineCore; each test reloads imem under reset, ports sampled on falling edges
`default_nettype none

module coreTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                          clk;
    logic                          rstN;
    logic                          loadEn;
    logic [coreTypes::addrW-1:0]   loadAddr;
    logic [coreTypes::xlen-1:0]    loadData;
    logic                          retireEn;
    logic [coreTypes::regIdxW-1:0] retireRd;
    logic [coreTypes::xlen-1:0]    retireData;
    logic                          storeEn;
    logic [coreTypes::addrW-1:0]   storeAddr;
    logic [coreTypes::xlen-1:0]    storeData;

    int testNum = 0;
    int testErrors = 0;
    int passed = 0;
    int failed = 0;
    int sinceRelease = 0;
    int firstRetire = -1;
    int usedCycles = 0;
    int budgetCycles = 0;

    pipelineCore dut_i (
        .clk, .rstN, .loadEn, .loadAddr, .loadData,
        .retireEn, .retireRd, .retireData, .storeEn, .storeAddr, .storeData
    );

    coreModel model_i ();

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic noteMismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("MISMATCH at %0t ns: %s expected 0x%h, actual 0x%h", $time, sig, exp, act);
        testErrors++;
    endtask

    task automatic reportProblem(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        testErrors++;
    endtask

    always @(negedge clk) begin : portCheck
        logic [4:0]  eRd;
        logic [31:0] eData;
        logic [5:0]  eAddr;
        if (rstN !== 1'b1) begin
            sinceRelease = 0;
            assert (retireEn === 1'b0 && storeEn === 1'b0)
                else reportProblem("retire or store port active while reset is asserted");
        end else begin
            sinceRelease++;
            if (retireEn === 1'b1) begin
                if (firstRetire < 0) firstRetire = sinceRelease;
                assert (retireRd !== 5'd0) else reportProblem("a write to x0 was retired");
                assert (model_i.retiresLeft() != 0)
                    else reportProblem($sformatf("unexpected retire of x%0d", retireRd));
                if (model_i.retiresLeft() != 0) begin
                    model_i.popRetire(eRd, eData);
                    assert (retireRd === eRd) else noteMismatch("retireRd", eRd, retireRd);
                    assert (retireData === eData) else noteMismatch("retireData", eData, retireData);
                end
            end
            if (storeEn === 1'b1) begin
                assert (model_i.storesLeft() != 0)
                    else reportProblem($sformatf("unexpected store to word %0d", storeAddr));
                if (model_i.storesLeft() != 0) begin
                    model_i.nextStore(eAddr, eData);
                    assert (storeAddr === eAddr) else noteMismatch("storeAddr", eAddr, storeAddr);
                    assert (storeData === eData) else noteMismatch("storeData", eData, storeData);
                end
            end
        end
    end

    // Budget grows with each test's load and program length
    always @(negedge clk) begin
        usedCycles++;
        if (usedCycles > budgetCycles) begin
            $display("Timeout: expected results of test %0d never appeared", testNum);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Reset stays low for at least 16 cycles and for the whole image
    task automatic loadProgram();
        for (int i = 0; i < 16 || i < coreTypes::imemDepth; i++) begin
            loadEn   <= (i < coreTypes::imemDepth);
            loadAddr <= coreTypes::addrW'(i);
            loadData <= model_i.prog[i % coreTypes::imemDepth];
            @(posedge clk);
        end
        loadEn <= 1'b0;
        rstN   <= 1'b1;
    endtask

    task automatic runTest(input int id, input string name);
        @(posedge clk);
        rstN <= 1'b0;
        testNum = id;
        model_i.buildProgram(id);
        budgetCycles += 16 + coreTypes::imemDepth + model_i.progLen + 20;
        testErrors = 0;
        firstRetire = -1;
        loadProgram();
        while (model_i.retiresLeft() + model_i.storesLeft() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);  // Catch stray retires
        if (id == 1) begin
            assert (firstRetire == 5)
                else reportProblem($sformatf("first retire %0d cycles after reset release, not 5",
                                             firstRetire));
        end
        if (testErrors == 0) begin
            passed++;
            $display("Test %0d %s: ok", id, name);
        end else begin
            failed++;
            $display("Test %0d %s: %0d errors", id, name, testErrors);
        end
    endtask

    initial begin
        rstN     = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        runTest(1, "reset and first retire");
        runTest(2, "dependent ALU chain");
        runTest(3, "load-use");
        runTest(4, "branches");
        runTest(5, "random program");
        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/coreTypes.sv
// Shared sizes and types; RV32I subset only, word accesses, addresses wrap at 64 words
`default_nettype none

package coreTypes;

    localparam int xlen = 32;
    localparam int regCount = 32;
    localparam int regIdxW = $clog2(regCount);  // 5-bit register index
    localparam int imemDepth = 64;
    localparam int dmemDepth = 64;
    localparam int addrW = $clog2(imemDepth);   // Word index, same for both memories

    // Major opcode field, instr[6:0]
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdMem  = 2'd1,
        fwdWb   = 2'd2
    } fwdSelT;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;
        logic  branchNe;
        logic  aluSrcImm;  // Second operand is the immediate
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic               valid;
        ctrlT               ctrl;
        logic [xlen-1:0]    pc;
        logic [regIdxW-1:0] rs1;
        logic [regIdxW-1:0] rs2;
        logic [regIdxW-1:0] rd;
        logic [xlen-1:0]    rData1;
        logic [xlen-1:0]    rData2;
        logic [xlen-1:0]    imm;
    } idExT;

    typedef struct packed {
        logic               valid;
        ctrlT               ctrl;
        logic [regIdxW-1:0] rd;
        logic [xlen-1:0]    aluResult;
        logic [xlen-1:0]    storeData;
    } exMemT;

    typedef struct packed {
        logic               valid;
        logic               regWrite;
        logic [regIdxW-1:0] rd;
        logic [xlen-1:0]    result;  // Load data or ALU result
    } memWbT;

endpackage

`default_nettype wire

//--- verilog/decodeUnit.sv
// Decodes only ADD SUB AND OR SLT ADDI LW SW BEQ BNE; anything else gets zero control
`default_nettype none

module decodeUnit (
    input  coreTypes::ifIdT                   ifId,
    output coreTypes::ctrlT                   ctrl,
    output logic [coreTypes::regIdxW-1:0]     rs1,
    output logic [coreTypes::regIdxW-1:0]     rs2,
    output logic [coreTypes::regIdxW-1:0]     rd,
    output logic [coreTypes::xlen-1:0]        imm
);

    logic [coreTypes::xlen-1:0] instr;
    logic [2:0]                 funct3;
    logic                       useRs2;

    assign instr  = ifId.instr;
    assign funct3 = instr[14:12];

    always_comb begin
        ctrl   = '0;
        useRs2 = 1'b0;
        imm    = {{20{instr[31]}}, instr[31:20]};  // I-type
        if (ifId.valid) begin
            case (coreTypes::opcodeT'(instr[6:0]))
                coreTypes::opReg: begin
                    useRs2        = 1'b1;
                    ctrl.regWrite = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.aluOp = instr[30] ? coreTypes::aluSub : coreTypes::aluAdd;
                        3'b111:  ctrl.aluOp = coreTypes::aluAnd;
                        3'b110:  ctrl.aluOp = coreTypes::aluOr;
                        3'b010:  ctrl.aluOp = coreTypes::aluSlt;
                        default: ctrl = '0;
                    endcase
                end
                coreTypes::opImm: begin
                    ctrl.regWrite  = (funct3 == 3'b000);  // ADDI only
                    ctrl.aluSrcImm = (funct3 == 3'b000);
                end
                coreTypes::opLoad: begin
                    ctrl.regWrite  = (funct3 == 3'b010);
                    ctrl.memRead   = (funct3 == 3'b010);
                    ctrl.aluSrcImm = (funct3 == 3'b010);
                end
                coreTypes::opStore: begin
                    useRs2         = 1'b1;
                    ctrl.memWrite  = (funct3 == 3'b010);
                    ctrl.aluSrcImm = (funct3 == 3'b010);
                    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
                coreTypes::opBranch: begin
                    useRs2        = 1'b1;
                    ctrl.branch   = (funct3[2:1] == 2'b00);  // BEQ or BNE
                    ctrl.branchNe = (funct3 == 3'b001);
                    ctrl.aluOp    = coreTypes::aluSub;
                    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
                end
                default: ctrl = '0;
            endcase
        end
    end

    // Unused source fields read as x0 so they never stall or forward
    assign rs1 = (|ctrl) ? instr[19:15] : '0;
    assign rs2 = ((|ctrl) && useRs2) ? instr[24:20] : '0;
    assign rd  = instr[11:7];

endmodule

`default_nettype wire

//--- verilog/executeUnit.sv
// Operand forwarding, ALU and branch resolution; SLT is signed, target is pc + imm
`default_nettype none

module executeUnit (
    input  coreTypes::idExT                   idEx,
    input  coreTypes::fwdSelT                 fwdA,
    input  coreTypes::fwdSelT                 fwdB,
    input  logic [coreTypes::xlen-1:0]        memResult,
    input  logic [coreTypes::xlen-1:0]        wbResult,
    output logic [coreTypes::xlen-1:0]        aluResult,
    output logic [coreTypes::xlen-1:0]        storeData,
    output logic                              branchTaken,
    output logic [coreTypes::xlen-1:0]        branchTarget
);

    function automatic logic [coreTypes::xlen-1:0] pick(
        input coreTypes::fwdSelT          sel,
        input logic [coreTypes::xlen-1:0] regVal,
        input logic [coreTypes::xlen-1:0] memVal,
        input logic [coreTypes::xlen-1:0] wbVal
    );
        case (sel)
            coreTypes::fwdMem: pick = memVal;
            coreTypes::fwdWb:  pick = wbVal;
            default:           pick = regVal;
        endcase
    endfunction

    logic [coreTypes::xlen-1:0] opA;
    logic [coreTypes::xlen-1:0] rs2Val;
    logic [coreTypes::xlen-1:0] opB;

    assign opA    = pick(fwdA, idEx.rData1, memResult, wbResult);
    assign rs2Val = pick(fwdB, idEx.rData2, memResult, wbResult);
    assign opB    = idEx.ctrl.aluSrcImm ? idEx.imm : rs2Val;

    always_comb begin
        case (idEx.ctrl.aluOp)
            coreTypes::aluAdd: aluResult = opA + opB;
            coreTypes::aluSub: aluResult = opA - opB;
            coreTypes::aluAnd: aluResult = opA & opB;
            coreTypes::aluOr:  aluResult = opA | opB;
            coreTypes::aluSlt: aluResult = {31'd0, $signed(opA) < $signed(opB)};
            default:           aluResult = '0;
        endcase
    end

    assign storeData = rs2Val;

    // Compare forwarded registers, never the immediate
    assign branchTaken  = idEx.valid && idEx.ctrl.branch &&
                          ((opA == rs2Val) != idEx.ctrl.branchNe);
    assign branchTarget = idEx.pc + idEx.imm;

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
// Load-use stall, branch flush and forwarding selects; memory stage beats writeback
`default_nettype none

module hazardUnit (
    input  logic [coreTypes::regIdxW-1:0] rs1,
    input  logic [coreTypes::regIdxW-1:0] rs2,
    input  coreTypes::idExT               idEx,
    input  coreTypes::exMemT              exMem,
    input  coreTypes::memWbT              memWb,
    input  logic                          branchTaken,
    output logic                          stall,
    output logic                          flush,
    output coreTypes::fwdSelT             fwdA,
    output coreTypes::fwdSelT             fwdB
);

    function automatic coreTypes::fwdSelT fwdFor(
        input logic [coreTypes::regIdxW-1:0] src,
        input coreTypes::exMemT              memStage,
        input coreTypes::memWbT              wbStage
    );
        if (memStage.valid && memStage.ctrl.regWrite && memStage.rd != '0 &&
            memStage.rd == src) begin
            fwdFor = coreTypes::fwdMem;
        end else if (wbStage.valid && wbStage.regWrite && wbStage.rd != '0 &&
                     wbStage.rd == src) begin
            fwdFor = coreTypes::fwdWb;
        end else begin
            fwdFor = coreTypes::fwdNone;
        end
    endfunction

    logic loadUse;

    // Load in execute feeding the instruction in decode
    assign loadUse = idEx.valid && idEx.ctrl.memRead && idEx.rd != '0 &&
                     (idEx.rd == rs1 || idEx.rd == rs2);

    assign flush = branchTaken;
    assign stall = loadUse && !branchTaken;  // Flush has priority

    assign fwdA = fwdFor(idEx.rs1, exMem, memWb);
    assign fwdB = fwdFor(idEx.rs2, exMem, memWb);

endmodule

`default_nettype wire

//--- verilog/pipelineCore.sv
// Five-stage core top; load imem only while rstN is low, store and retire ports are combinational
`default_nettype none

module pipelineCore (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              loadEn,
    input  logic [coreTypes::addrW-1:0]       loadAddr,
    input  logic [coreTypes::xlen-1:0]        loadData,
    output logic                              retireEn,
    output logic [coreTypes::regIdxW-1:0]     retireRd,
    output logic [coreTypes::xlen-1:0]        retireData,
    output logic                              storeEn,
    output logic [coreTypes::addrW-1:0]       storeAddr,
    output logic [coreTypes::xlen-1:0]        storeData
);

    logic [coreTypes::xlen-1:0]    pc;
    logic [coreTypes::xlen-1:0]    instr;
    coreTypes::ifIdT               ifId;
    coreTypes::idExT               idEx;
    coreTypes::idExT               idExNext;
    coreTypes::exMemT              exMem;
    coreTypes::exMemT              exMemNext;
    coreTypes::memWbT              memWb;
    coreTypes::memWbT              memWbNext;
    coreTypes::ctrlT               ctrl;
    logic [coreTypes::regIdxW-1:0] rs1;
    logic [coreTypes::regIdxW-1:0] rs2;
    logic [coreTypes::regIdxW-1:0] rd;
    logic [coreTypes::xlen-1:0]    imm;
    logic [coreTypes::xlen-1:0]    rData1;
    logic [coreTypes::xlen-1:0]    rData2;
    logic                          stall;
    logic                          flush;
    coreTypes::fwdSelT             fwdA;
    coreTypes::fwdSelT             fwdB;
    logic [coreTypes::xlen-1:0]    aluResult;
    logic [coreTypes::xlen-1:0]    exStoreData;
    logic                          branchTaken;
    logic [coreTypes::xlen-1:0]    branchTarget;
    logic                          dmemWe;
    logic [coreTypes::addrW-1:0]   dmemAddr;
    logic [coreTypes::xlen-1:0]    dmemRData;

    pipelineRegisters stages_i (
        .clk, .rstN, .stall, .flush, .branchTarget, .instr,
        .idExNext, .exMemNext, .memWbNext,
        .pc, .ifId, .idEx, .exMem, .memWb
    );

    wordMemory #(.depth(coreTypes::imemDepth)) imem_i (
        .clk, .we(loadEn), .wAddr(loadAddr), .wData(loadData),
        .rAddr(pc[coreTypes::addrW+1:2]), .rData(instr)
    );

    decodeUnit decode_i (.ifId, .ctrl, .rs1, .rs2, .rd, .imm);

    regFile regs_i (
        .clk, .rstN, .we(memWb.valid && memWb.regWrite), .wAddr(memWb.rd),
        .wData(memWb.result), .rAddr1(rs1), .rAddr2(rs2), .rData1, .rData2
    );

    assign idExNext = '{valid: ifId.valid, ctrl: ctrl, pc: ifId.pc, rs1: rs1, rs2: rs2,
                        rd: rd, rData1: rData1, rData2: rData2, imm: imm};

    hazardUnit hazard_i (.rs1, .rs2, .idEx, .exMem, .memWb, .branchTaken,
                         .stall, .flush, .fwdA, .fwdB);

    executeUnit execute_i (
        .idEx, .fwdA, .fwdB, .memResult(exMem.aluResult), .wbResult(memWb.result),
        .aluResult, .storeData(exStoreData), .branchTaken, .branchTarget
    );

    assign exMemNext = '{valid: idEx.valid, ctrl: idEx.ctrl, rd: idEx.rd,
                         aluResult: aluResult, storeData: exStoreData};

    // Data memory indexed by the word part of the ALU address
    assign dmemWe   = exMem.valid && exMem.ctrl.memWrite;
    assign dmemAddr = exMem.aluResult[coreTypes::addrW+1:2];

    wordMemory #(.depth(coreTypes::dmemDepth)) dmem_i (
        .clk, .we(dmemWe), .wAddr(dmemAddr), .wData(exMem.storeData),
        .rAddr(dmemAddr), .rData(dmemRData)
    );

    assign memWbNext = '{valid: exMem.valid, regWrite: exMem.ctrl.regWrite, rd: exMem.rd,
                         result: exMem.ctrl.memRead ? dmemRData : exMem.aluResult};

    assign retireEn   = memWb.valid && memWb.regWrite && (memWb.rd != '0);
    assign retireRd   = memWb.rd;
    assign retireData = memWb.result;

    assign storeEn   = dmemWe;  // Mirrors the data-memory write
    assign storeAddr = dmemAddr;
    assign storeData = exMem.storeData;

endmodule

`default_nettype wire

//--- verilog/pipelineRegisters.sv
// PC and stage registers; flush wins over stall, bubbles are all-zero with valid low
`default_nettype none

module pipelineRegisters (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       stall,
    input  logic                       flush,
    input  logic [coreTypes::xlen-1:0] branchTarget,
    input  logic [coreTypes::xlen-1:0] instr,
    input  coreTypes::idExT            idExNext,
    input  coreTypes::exMemT           exMemNext,
    input  coreTypes::memWbT           memWbNext,
    output logic [coreTypes::xlen-1:0] pc,
    output coreTypes::ifIdT            ifId,
    output coreTypes::idExT            idEx,
    output coreTypes::exMemT           exMem,
    output coreTypes::memWbT           memWb
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (flush) begin
            pc <= branchTarget;  // Redirect to taken branch
        end else if (!stall) begin
            pc <= pc + coreTypes::xlen'(4);
        end
    end

    // Fetch/decode
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifId <= '0;
        end else if (flush) begin
            ifId <= '0;
        end else if (!stall) begin
            ifId <= '{valid: 1'b1, pc: pc, instr: instr};
        end
    end

    // Decode/execute, bubble on load-use or flush
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (flush || stall) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

    // Later stages never hold
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
            memWb <= '0;
        end else begin
            exMem <= exMemNext;
            memWb <= memWbNext;
        end
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
// Two read ports, one write port; x0 reads zero, same-cycle write is visible on reads
`default_nettype none

module regFile (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              we,
    input  logic [coreTypes::regIdxW-1:0]     wAddr,
    input  logic [coreTypes::xlen-1:0]        wData,
    input  logic [coreTypes::regIdxW-1:0]     rAddr1,
    input  logic [coreTypes::regIdxW-1:0]     rAddr2,
    output logic [coreTypes::xlen-1:0]        rData1,
    output logic [coreTypes::xlen-1:0]        rData2
);

    logic [coreTypes::xlen-1:0] regs [coreTypes::regCount];
    logic                       wrLive;

    assign wrLive = we && (wAddr != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < coreTypes::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wAddr] <= wData;
        end
    end

    // Write-through covers writeback feeding decode
    assign rData1 = (wrLive && wAddr == rAddr1) ? wData : regs[rAddr1];
    assign rData2 = (wrLive && wAddr == rAddr2) ? wData : regs[rAddr2];

endmodule

`default_nettype wire

//--- verilog/wordMemory.sv
// Word memory, combinational read and clocked write; contents start unknown and have no reset
`default_nettype none

module wordMemory #(
    parameter int depth = coreTypes::imemDepth
) (
    input  logic                       clk,
    input  logic                       we,
    input  logic [coreTypes::addrW-1:0] wAddr,
    input  logic [coreTypes::xlen-1:0] wData,
    input  logic [coreTypes::addrW-1:0] rAddr,
    output logic [coreTypes::xlen-1:0] rData
);

    logic [coreTypes::xlen-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wAddr] <= wData;
        end
    end

    assign rData = mem[rAddr];  // Same-cycle read

endmodule

`default_nettype wire
